// File: list.f
+incdir+.
axil_regs_pkg.sv
bank_if.sv
axil_write_port.sv
axil_read_port.sv
bank_arbiter.sv
reg_bank.sv
axil_reg_slave.sv
axil_slave_props.sv
tb_axil_reg_slave.sv

// File: tb_axil_reg_slave.sv
////////////////////////////////////////
// Testbench for the AXI-lite register slave
// Table-driven writes and reads, checked
// against a bank model
////////////////////////////////////////

`include "axil_regs_config.svh"

module tb_axil_reg_slave;

	localparam int RESET_CYCLES = 16;
	localparam int NUM_ROWS = 22;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 40 * (NUM_ROWS + `AXIL_REG_COUNT);
	// Row operations
	localparam logic [1:0] OP_WR = 2'd0;
	localparam logic [1:0] OP_RD = 2'd1;
	localparam logic [1:0] OP_WR_RD = 2'd2;
	// AW and W ordering
	localparam logic [1:0] ORD_BOTH = 2'd0;
	localparam logic [1:0] ORD_AW_FIRST = 2'd1;
	localparam logic [1:0] ORD_W_FIRST = 2'd2;
	// AXI response codes
	localparam logic [1:0] EXP_OKAY = 2'b00;
	localparam logic [1:0] EXP_SLVERR = 2'b10;

	typedef struct packed {
		logic [1:0] op;
		logic [`AXIL_ADDR_W-1:0] addr;
		logic [`AXIL_DATA_W-1:0] data;
		logic [3:0] strb;
		logic [1:0] order;
		logic [`AXIL_ADDR_W-1:0] rd_addr;
	} row_t;

	logic i_clk;
	logic i_axi_reset_n;
	logic i_axi_awvalid;
	logic o_axi_awready;
	logic [`AXIL_ADDR_W-1:0] i_axi_awaddr;
	logic i_axi_wvalid;
	logic o_axi_wready;
	logic [`AXIL_DATA_W-1:0] i_axi_wdata;
	logic [3:0] i_axi_wstrb;
	logic o_axi_bvalid;
	logic i_axi_bready;
	logic [1:0] o_axi_bresp;
	logic i_axi_arvalid;
	logic o_axi_arready;
	logic [`AXIL_ADDR_W-1:0] i_axi_araddr;
	logic o_axi_rvalid;
	logic i_axi_rready;
	logic [`AXIL_DATA_W-1:0] o_axi_rdata;
	logic [1:0] o_axi_rresp;

	row_t stim [NUM_ROWS];
	// Bank model
	logic [31:0] model [`AXIL_REG_COUNT];
	logic [31:0] lfsr_state;
	int cycle_count = 0;
	int error_count = 0;

	axil_reg_slave DUT (.*);

	bind axil_reg_slave axil_slave_props u_props (.*);

	initial
		i_clk = 1'b0;
	always
		#5 i_clk = ~i_clk;

	// Run limit
	always @(posedge i_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_with_failure($sformatf("Timeout, test did not finish in %0d cycles",
				TIMEOUT_CYCLES));
	end

	task automatic stop_with_failure(input string msg);
		error_count++;
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic expect_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
			stop_with_failure($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	////////////////////////////////////////
	// Stall source
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		// Taps 32, 22, 2, 1
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Two bits give 0 to 3 stall cycles
	task automatic take_stall(output int n);
		n = 0;
		repeat (2)
		begin
			n = (n << 1) | lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic row_t make_row(input logic [1:0] op, input logic [11:0] addr,
		input logic [31:0] data, input logic [3:0] strb, input logic [1:0] order,
		input logic [11:0] rd_addr);
		make_row = {op, addr, data, strb, order, rd_addr};
	endfunction

	task automatic fill_table();
		// Full strobes in all three orders and read back
		stim[0] = make_row(OP_WR, 12'h000, 32'hdead_beef, 4'hf, ORD_BOTH, 12'h0);
		stim[1] = make_row(OP_RD, 12'h000, 32'h0, 4'h0, ORD_BOTH, 12'h0);
		stim[2] = make_row(OP_WR, 12'h004, 32'h1234_5678, 4'hf, ORD_AW_FIRST, 12'h0);
		stim[3] = make_row(OP_RD, 12'h004, 32'h0, 4'h0, ORD_BOTH, 12'h0);
		stim[4] = make_row(OP_WR, 12'h008, 32'hcafe_f00d, 4'hf, ORD_W_FIRST, 12'h0);
		stim[5] = make_row(OP_RD, 12'h008, 32'h0, 4'h0, ORD_BOTH, 12'h0);
		// Partial strobes
		stim[6] = make_row(OP_WR, 12'h004, 32'haabb_ccdd, 4'h1, ORD_BOTH, 12'h0);
		stim[7] = make_row(OP_WR, 12'h004, 32'h1122_3344, 4'h6, ORD_W_FIRST, 12'h0);
		stim[8] = make_row(OP_RD, 12'h004, 32'h0, 4'h0, ORD_BOTH, 12'h0);
		stim[9] = make_row(OP_WR, 12'h00c, 32'h5566_7788, 4'h8, ORD_AW_FIRST, 12'h0);
		stim[10] = make_row(OP_RD, 12'h00c, 32'h0, 4'h0, ORD_BOTH, 12'h0);
		// Past the bank and a readback of the bank
		stim[11] = make_row(OP_WR, 12'h040, 32'hffff_ffff, 4'hf, ORD_BOTH, 12'h0);
		stim[12] = make_row(OP_RD, 12'h040, 32'h0, 4'h0, ORD_BOTH, 12'h0);
		stim[13] = make_row(OP_RD, 12'h000, 32'h0, 4'h0, ORD_BOTH, 12'h0);
		stim[14] = make_row(OP_WR, 12'hffc, 32'h0bad_f00d, 4'hf, ORD_W_FIRST, 12'h0);
		stim[15] = make_row(OP_RD, 12'hffc, 32'h0, 4'h0, ORD_BOTH, 12'h0);
		// Read alongside a pending write
		stim[16] = make_row(OP_WR_RD, 12'h010, 32'ha5a5_a5a5, 4'hf, ORD_BOTH, 12'h000);
		stim[17] = make_row(OP_WR_RD, 12'h03c, 32'h0f0f_0f0f, 4'h5, ORD_AW_FIRST, 12'h010);
		stim[18] = make_row(OP_WR_RD, 12'h014, 32'h8765_4321, 4'hf, ORD_W_FIRST, 12'h0f0);
		stim[19] = make_row(OP_RD, 12'h03c, 32'h0, 4'h0, ORD_BOTH, 12'h0);
		stim[20] = make_row(OP_RD, 12'h014, 32'h0, 4'h0, ORD_BOTH, 12'h0);
		stim[21] = make_row(OP_WR_RD, 12'h080, 32'h7777_7777, 4'hf, ORD_BOTH, 12'h014);
	endtask

	////////////////////////////////////////
	// Bus tasks start and end just after a falling edge
	task automatic do_write(input logic [11:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] order, input int stall,
		output logic [1:0] resp, output int lat);
		logic aw_done;
		logic w_done;
		logic aw_fire;
		logic w_fire;
		aw_done = 1'b0;
		w_done = 1'b0;
		i_axi_awaddr = addr;
		i_axi_wdata = data;
		i_axi_wstrb = strb;
		i_axi_awvalid = (order != ORD_W_FIRST);
		i_axi_wvalid = (order != ORD_AW_FIRST);
		while (!(aw_done && w_done))
		begin
			// Handshake lands on the next rising edge
			aw_fire = i_axi_awvalid && o_axi_awready;
			w_fire = i_axi_wvalid && o_axi_wready;
			@(negedge i_clk);
			if (aw_fire)
			begin
				i_axi_awvalid = 1'b0;
				aw_done = 1'b1;
			end
			if (w_fire)
			begin
				i_axi_wvalid = 1'b0;
				w_done = 1'b1;
			end
			// Second channel follows the first
			if (aw_done && !w_done)
				i_axi_wvalid = 1'b1;
			if (w_done && !aw_done)
				i_axi_awvalid = 1'b1;
		end
		// Count edges from the last handshake
		lat = 1;
		while (!o_axi_bvalid)
		begin
			assert (!o_axi_awready && !o_axi_wready)
			else
				stop_with_failure($sformatf("ERR %0t: write channel open before B", $time));
			@(negedge i_clk);
			lat++;
		end
		resp = o_axi_bresp;
		repeat (stall)
		begin
			@(negedge i_clk);
			assert (o_axi_bvalid && o_axi_bresp === resp)
			else
				stop_with_failure($sformatf("ERR %0t: B response not held under stall", $time));
		end
		i_axi_bready = 1'b1;
		@(negedge i_clk);
		i_axi_bready = 1'b0;
		assert (!o_axi_bvalid)
		else
			stop_with_failure($sformatf("ERR %0t: bvalid still high after B handshake", $time));
	endtask

	task automatic do_read(input logic [11:0] addr, input int stall,
		output logic [31:0] data, output logic [1:0] resp, output int lat);
		logic ar_fire;
		i_axi_araddr = addr;
		i_axi_arvalid = 1'b1;
		do
		begin
			ar_fire = o_axi_arready;
			@(negedge i_clk);
		end
		while (!ar_fire);
		i_axi_arvalid = 1'b0;
		lat = 1;
		while (!o_axi_rvalid)
		begin
			assert (!o_axi_arready)
			else
				stop_with_failure($sformatf("ERR %0t: arready high before R", $time));
			@(negedge i_clk);
			lat++;
		end
		data = o_axi_rdata;
		resp = o_axi_rresp;
		repeat (stall)
		begin
			@(negedge i_clk);
			assert (o_axi_rvalid && o_axi_rdata === data && o_axi_rresp === resp)
			else
				stop_with_failure($sformatf("ERR %0t: R response not held under stall", $time));
		end
		i_axi_rready = 1'b1;
		@(negedge i_clk);
		i_axi_rready = 1'b0;
		assert (!o_axi_rvalid)
		else
			stop_with_failure($sformatf("ERR %0t: rvalid still high after R handshake", $time));
	endtask

	////////////////////////////////////////
	// Checks against the model
	task automatic check_write(input row_t r, input logic contended, input int stall);
		logic [1:0] resp;
		int lat;
		int idx;
		idx = r.addr[`AXIL_ADDR_W-1:2];
		do_write(r.addr, r.data, r.strb, r.order, stall, resp, lat);
		if (idx < `AXIL_REG_COUNT)
		begin
			expect_equal("bresp", resp, EXP_OKAY);
			for (int b = 0; b < 4; b++)
				if (r.strb[b])
					model[idx][8*b +: 8] = r.data[8*b +: 8];
			// 2 cycles when free and 3 when the read port holds the bank
			if (!contended)
				expect_equal("write latency", lat, 2);
			else
				assert (lat == 2 || lat == 3)
				else
					stop_with_failure($sformatf("ERR %0t: write latency %0d", $time, lat));
		end
		else
		begin
			expect_equal("bresp", resp, EXP_SLVERR);
			expect_equal("error write latency", lat, 1);
		end
	endtask

	task automatic check_read(input logic [11:0] addr, input logic contended,
		input int stall);
		logic [31:0] data;
		logic [1:0] resp;
		int lat;
		int idx;
		idx = addr[`AXIL_ADDR_W-1:2];
		do_read(addr, stall, data, resp, lat);
		if (idx < `AXIL_REG_COUNT)
		begin
			expect_equal("rresp", resp, EXP_OKAY);
			expect_equal("rdata", data, model[idx]);
			if (!contended)
				expect_equal("read latency", lat, 3);
			else
				assert (lat == 3 || lat == 4)
				else
					stop_with_failure($sformatf("ERR %0t: read latency %0d", $time, lat));
		end
		else
		begin
			// Out of range reads return zero
			expect_equal("rresp", resp, EXP_SLVERR);
			expect_equal("error rdata", data, 32'h0);
			expect_equal("error read latency", lat, 1);
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	initial
	begin
		int wr_stall;
		int rd_stall;
		i_axi_reset_n = 1'b0;
		i_axi_awvalid = 1'b0;
		i_axi_awaddr = '0;
		i_axi_wvalid = 1'b0;
		i_axi_wdata = '0;
		i_axi_wstrb = '0;
		i_axi_bready = 1'b0;
		i_axi_arvalid = 1'b0;
		i_axi_araddr = '0;
		i_axi_rready = 1'b0;
		lfsr_state = 32'hbc76_4a10;
		fill_table();
		for (int w = 0; w < `AXIL_REG_COUNT; w++)
			model[w] = '0;
		repeat (RESET_CYCLES) @(negedge i_clk);
		i_axi_reset_n = 1'b1;
		// No responses and all channels open after reset
		repeat (3)
		begin
			@(negedge i_clk);
			assert (!o_axi_bvalid && !o_axi_rvalid && o_axi_awready && o_axi_wready
				&& o_axi_arready)
			else
				stop_with_failure($sformatf("ERR %0t: wrong idle state after reset", $time));
		end
		// Every word starts at zero
		for (int w = 0; w < `AXIL_REG_COUNT; w++)
		begin
			take_stall(rd_stall);
			check_read(w * 4, 1'b0, rd_stall);
		end
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			// Stalls drawn here so both forked sides see a fixed order
			case (stim[i].op)
				OP_WR:
				begin
					take_stall(wr_stall);
					check_write(stim[i], 1'b0, wr_stall);
				end
				OP_RD:
				begin
					take_stall(rd_stall);
					check_read(stim[i].addr, 1'b0, rd_stall);
				end
				default:
				begin
					take_stall(wr_stall);
					take_stall(rd_stall);
					fork
						check_write(stim[i], 1'b1, wr_stall);
						check_read(stim[i].rd_addr, 1'b1, rd_stall);
					join
				end
			endcase
		end
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: axil_slave_props.sv
////////////////////////////////////////
// AXI-lite slave protocol checks
// Bound onto the register slave top
////////////////////////////////////////

`include "axil_regs_config.svh"

module axil_slave_props (
	input logic i_clk,
	input logic i_axi_reset_n,
	input logic i_axi_awvalid,
	input logic o_axi_awready,
	input logic i_axi_wvalid,
	input logic o_axi_wready,
	input logic o_axi_bvalid,
	input logic i_axi_bready,
	input logic [1:0] o_axi_bresp,
	input logic i_axi_arvalid,
	input logic o_axi_arready,
	input logic o_axi_rvalid,
	input logic i_axi_rready,
	input logic [`AXIL_DATA_W-1:0] o_axi_rdata,
	input logic [1:0] o_axi_rresp
);

	// Outstanding requests per channel
	logic [1:0] aw_cnt;
	logic [1:0] w_cnt;
	logic [1:0] ar_cnt;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			aw_cnt <= '0;
			w_cnt <= '0;
			ar_cnt <= '0;
		end
		else
		begin
			// B handshake retires both AW and W
			aw_cnt <= aw_cnt + (i_axi_awvalid && o_axi_awready) - (o_axi_bvalid && i_axi_bready);
			w_cnt <= w_cnt + (i_axi_wvalid && o_axi_wready) - (o_axi_bvalid && i_axi_bready);
			ar_cnt <= ar_cnt + (i_axi_arvalid && o_axi_arready) - (o_axi_rvalid && i_axi_rready);
		end
	end

	////////////////////////////////////////
	// Reset behavior
	reset_quiet: assert property (@(posedge i_clk)
		!i_axi_reset_n |=> !o_axi_bvalid && !o_axi_rvalid)
		else $error("response valid high during or just after reset");

	// Responses hold under back-pressure
	b_stable: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		o_axi_bvalid && !i_axi_bready |=> o_axi_bvalid && $stable(o_axi_bresp))
		else $error("B response changed before bready");
	r_stable: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		o_axi_rvalid && !i_axi_rready |=>
		o_axi_rvalid && $stable(o_axi_rresp) && $stable(o_axi_rdata))
		else $error("R response changed before rready");

	// One in flight per channel
	one_outstanding: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		aw_cnt <= 1 && w_cnt <= 1 && ar_cnt <= 1)
		else $error("more than one outstanding transaction on a channel");

	// Responses only follow requests
	b_after_req: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		o_axi_bvalid |-> aw_cnt != 0 && w_cnt != 0)
		else $error("bvalid without a write request");
	r_after_req: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		o_axi_rvalid |-> ar_cnt != 0)
		else $error("rvalid without a read request");

	// EXOKAY is never legal here
	no_exokay: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(o_axi_bvalid |-> o_axi_bresp != 2'b01) and (o_axi_rvalid |-> o_axi_rresp != 2'b01))
		else $error("EXOKAY response seen");

endmodule

// File: axil_reg_slave.sv
////////////////////////////////////////
// AXI-lite register slave, top level
// Write and read ports share one bank
////////////////////////////////////////

`include "axil_regs_config.svh"

module axil_reg_slave (
	input logic i_clk,
	input logic i_axi_reset_n,
	// Write address
	input logic i_axi_awvalid,
	output logic o_axi_awready,
	input logic [`AXIL_ADDR_W-1:0] i_axi_awaddr,
	// Write data
	input logic i_axi_wvalid,
	output logic o_axi_wready,
	input logic [`AXIL_DATA_W-1:0] i_axi_wdata,
	input logic [`AXIL_DATA_W/8-1:0] i_axi_wstrb,
	// Write response
	output logic o_axi_bvalid,
	input logic i_axi_bready,
	output axil_regs_pkg::axil_resp_t o_axi_bresp,
	// Read address
	input logic i_axi_arvalid,
	output logic o_axi_arready,
	input logic [`AXIL_ADDR_W-1:0] i_axi_araddr,
	// Read data
	output logic o_axi_rvalid,
	input logic i_axi_rready,
	output logic [`AXIL_DATA_W-1:0] o_axi_rdata,
	output axil_regs_pkg::axil_resp_t o_axi_rresp
);

	// Shared bank access bus
	logic bank_we;
	axil_regs_pkg::reg_index_t bank_index;
	axil_regs_pkg::axil_data_t bank_wdata;
	axil_regs_pkg::axil_strb_t bank_wstrb;
	axil_regs_pkg::axil_data_t bank_rdata;

	bank_if wr_bank ();
	bank_if rd_bank ();

	////////////////////////////////////////
	// Channel ports
	axil_write_port u_write_port (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_awvalid(i_axi_awvalid), .o_awready(o_axi_awready), .i_awaddr(i_axi_awaddr),
		.i_wvalid(i_axi_wvalid), .o_wready(o_axi_wready),
		.i_wdata(i_axi_wdata), .i_wstrb(i_axi_wstrb),
		.o_bvalid(o_axi_bvalid), .i_bready(i_axi_bready), .o_bresp(o_axi_bresp),
		.bank(wr_bank)
	);

	axil_read_port u_read_port (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_arvalid(i_axi_arvalid), .o_arready(o_axi_arready), .i_araddr(i_axi_araddr),
		.o_rvalid(o_axi_rvalid), .i_rready(i_axi_rready),
		.o_rdata(o_axi_rdata), .o_rresp(o_axi_rresp),
		.bank(rd_bank)
	);

	////////////////////////////////////////
	// Arbitration and storage
	bank_arbiter u_arbiter (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.wr_port(wr_bank), .rd_port(rd_bank),
		.o_bank_we(bank_we), .o_bank_index(bank_index),
		.o_bank_wdata(bank_wdata), .o_bank_wstrb(bank_wstrb),
		.i_bank_rdata(bank_rdata)
	);

	reg_bank u_bank (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_we(bank_we), .i_index(bank_index),
		.i_wdata(bank_wdata), .i_wstrb(bank_wstrb),
		.o_rdata(bank_rdata)
	);

endmodule

// File: reg_bank.sv
////////////////////////////////////////
// Register bank
// Byte-strobed write, registered read
////////////////////////////////////////

`include "axil_regs_config.svh"

module reg_bank (
	input logic i_clk,
	input logic i_axi_reset_n,
	input logic i_we,
	input axil_regs_pkg::reg_index_t i_index,
	input axil_regs_pkg::axil_data_t i_wdata,
	input axil_regs_pkg::axil_strb_t i_wstrb,
	output axil_regs_pkg::axil_data_t o_rdata
);

	axil_regs_pkg::axil_data_t mem [`AXIL_REG_COUNT];

	// Storage, all words zero after reset
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			for (int w = 0; w < `AXIL_REG_COUNT; w++)
				mem[w] <= '0;
		end
		else if (i_we)
		begin
			// Only enabled bytes change
			for (int b = 0; b < $bits(axil_regs_pkg::axil_strb_t); b++)
				if (i_wstrb[b])
					mem[i_index][8*b +: 8] <= i_wdata[8*b +: 8];
		end
	end

	// Read word every clock, old value on a same-edge write
	always_ff @(posedge i_clk)
		o_rdata <= mem[i_index];

endmodule

// File: bank_arbiter.sv
////////////////////////////////////////
// Bank arbiter
// Round-robin between write and read port
////////////////////////////////////////

module bank_arbiter (
	input logic i_clk,
	input logic i_axi_reset_n,
	bank_if.arbiter wr_port,
	bank_if.arbiter rd_port,
	output logic o_bank_we,
	output axil_regs_pkg::reg_index_t o_bank_index,
	output axil_regs_pkg::axil_data_t o_bank_wdata,
	output axil_regs_pkg::axil_strb_t o_bank_wstrb,
	input axil_regs_pkg::axil_data_t i_bank_rdata
);

	// High when the read port had the last grant
	logic last_rd;
	logic wr_gnt;
	logic rd_gnt;

	// Tie goes to whoever waited
	assign wr_gnt = wr_port.req && (!rd_port.req || last_rd);
	assign rd_gnt = rd_port.req && (!wr_port.req || !last_rd);

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			last_rd <= 1'b0;
		else if (wr_gnt)
			last_rd <= 1'b0;
		else if (rd_gnt)
			last_rd <= 1'b1;
	end

	assign wr_port.gnt = wr_gnt;
	assign rd_port.gnt = rd_gnt;

	// Granted requester drives the bank
	assign o_bank_we = (wr_gnt && wr_port.we) || (rd_gnt && rd_port.we);
	assign o_bank_index = rd_gnt ? rd_port.index : wr_port.index;
	assign o_bank_wdata = rd_gnt ? rd_port.wdata : wr_port.wdata;
	assign o_bank_wstrb = rd_gnt ? rd_port.wstrb : wr_port.wstrb;

	// Read word goes back to both
	assign wr_port.rdata = i_bank_rdata;
	assign rd_port.rdata = i_bank_rdata;

endmodule

// File: axil_read_port.sv
////////////////////////////////////////
// AXI-lite read port
// Range checks AR, reads the bank,
// holds R until accepted
////////////////////////////////////////

`include "axil_regs_config.svh"

module axil_read_port (
	input logic i_clk,
	input logic i_axi_reset_n,
	input logic i_arvalid,
	output logic o_arready,
	input axil_regs_pkg::axil_addr_t i_araddr,
	output logic o_rvalid,
	input logic i_rready,
	output axil_regs_pkg::axil_data_t o_rdata,
	output axil_regs_pkg::axil_resp_t o_rresp,
	bank_if.requester bank
);

	axil_regs_pkg::rd_state_t state;
	logic ar_fire;
	logic addr_err;
	axil_regs_pkg::reg_index_t index_q;
	axil_regs_pkg::axil_data_t rdata_q;
	axil_regs_pkg::axil_resp_t rresp_q;

	// One read at a time, AR closed until R handshake
	assign o_arready = (state == axil_regs_pkg::RD_IDLE);
	assign ar_fire = i_arvalid && o_arready;
	assign addr_err = i_araddr[`AXIL_ADDR_W-1:2] >= `AXIL_REG_COUNT;

	////////////////////////////////////////
	// Control FSM
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			state <= axil_regs_pkg::RD_IDLE;
		else
		begin
			case (state)
				axil_regs_pkg::RD_IDLE:
					if (ar_fire)
						state <= addr_err ? axil_regs_pkg::RD_RESP : axil_regs_pkg::RD_BANK;
				axil_regs_pkg::RD_BANK:
					if (bank.gnt)
						state <= axil_regs_pkg::RD_WAIT;
				// Bank output registers during this cycle
				axil_regs_pkg::RD_WAIT:
					state <= axil_regs_pkg::RD_RESP;
				axil_regs_pkg::RD_RESP:
					if (i_rready)
						state <= axil_regs_pkg::RD_IDLE;
				default:
					state <= axil_regs_pkg::RD_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Payload capture
	always_ff @(posedge i_clk)
	begin
		if (ar_fire)
		begin
			index_q <= i_araddr[2 +: $bits(axil_regs_pkg::reg_index_t)];
			rresp_q <= addr_err ? axil_regs_pkg::RESP_SLVERR : axil_regs_pkg::RESP_OKAY;
			// Out-of-range read returns zero
			if (addr_err)
				rdata_q <= '0;
		end
		if (state == axil_regs_pkg::RD_WAIT)
			rdata_q <= bank.rdata;
	end

	// Read-only requester
	assign bank.req = (state == axil_regs_pkg::RD_BANK);
	assign bank.we = 1'b0;
	assign bank.index = index_q;
	assign bank.wdata = '0;
	assign bank.wstrb = '0;

	// R channel
	assign o_rvalid = (state == axil_regs_pkg::RD_RESP);
	assign o_rdata = rdata_q;
	assign o_rresp = rresp_q;

endmodule

// File: axil_write_port.sv
////////////////////////////////////////
// AXI-lite write port
// Collects AW and W, range checks,
// writes the bank, returns B
////////////////////////////////////////

`include "axil_regs_config.svh"

module axil_write_port (
	input logic i_clk,
	input logic i_axi_reset_n,
	input logic i_awvalid,
	output logic o_awready,
	input axil_regs_pkg::axil_addr_t i_awaddr,
	input logic i_wvalid,
	output logic o_wready,
	input axil_regs_pkg::axil_data_t i_wdata,
	input axil_regs_pkg::axil_strb_t i_wstrb,
	output logic o_bvalid,
	input logic i_bready,
	output axil_regs_pkg::axil_resp_t o_bresp,
	bank_if.requester bank
);

	axil_regs_pkg::wr_state_t state;
	logic have_aw;
	logic have_w;
	logic aw_fire;
	logic w_fire;
	logic both_done;
	logic addr_err;
	axil_regs_pkg::axil_addr_t addr_sel;
	axil_regs_pkg::axil_addr_t awaddr_q;
	axil_regs_pkg::axil_data_t wdata_q;
	axil_regs_pkg::axil_strb_t wstrb_q;
	axil_regs_pkg::axil_resp_t bresp_q;

	// Each channel closes after its own handshake
	assign o_awready = (state == axil_regs_pkg::WR_COLLECT) && !have_aw;
	assign o_wready = (state == axil_regs_pkg::WR_COLLECT) && !have_w;
	assign aw_fire = i_awvalid && o_awready;
	assign w_fire = i_wvalid && o_wready;
	assign both_done = (have_aw || aw_fire) && (have_w || w_fire);

	// Address may arrive on this very edge
	assign addr_sel = have_aw ? awaddr_q : i_awaddr;
	// Word address past the bank
	assign addr_err = addr_sel[`AXIL_ADDR_W-1:2] >= `AXIL_REG_COUNT;

	////////////////////////////////////////
	// Control FSM
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			state <= axil_regs_pkg::WR_COLLECT;
			have_aw <= 1'b0;
			have_w <= 1'b0;
		end
		else
		begin
			case (state)
				axil_regs_pkg::WR_COLLECT:
				begin
					if (both_done)
					begin
						have_aw <= 1'b0;
						have_w <= 1'b0;
						// Errors skip the bank entirely
						state <= addr_err ? axil_regs_pkg::WR_RESP : axil_regs_pkg::WR_BANK;
					end
					else
					begin
						if (aw_fire)
							have_aw <= 1'b1;
						if (w_fire)
							have_w <= 1'b1;
					end
				end
				// Write lands on the granted edge
				axil_regs_pkg::WR_BANK:
					if (bank.gnt)
						state <= axil_regs_pkg::WR_RESP;
				axil_regs_pkg::WR_RESP:
					if (i_bready)
						state <= axil_regs_pkg::WR_COLLECT;
				default:
					state <= axil_regs_pkg::WR_COLLECT;
			endcase
		end
	end

	////////////////////////////////////////
	// Payload capture
	always_ff @(posedge i_clk)
	begin
		if (aw_fire)
			awaddr_q <= i_awaddr;
		if (w_fire)
		begin
			wdata_q <= i_wdata;
			wstrb_q <= i_wstrb;
		end
		if ((state == axil_regs_pkg::WR_COLLECT) && both_done)
			bresp_q <= addr_err ? axil_regs_pkg::RESP_SLVERR : axil_regs_pkg::RESP_OKAY;
	end

	// Bank request, fields steady through WR_BANK
	assign bank.req = (state == axil_regs_pkg::WR_BANK);
	assign bank.we = 1'b1;
	assign bank.index = awaddr_q[2 +: $bits(axil_regs_pkg::reg_index_t)];
	assign bank.wdata = wdata_q;
	assign bank.wstrb = wstrb_q;

	// B channel
	assign o_bvalid = (state == axil_regs_pkg::WR_RESP);
	assign o_bresp = bresp_q;

endmodule

// File: bank_if.sv
////////////////////////////////////////
// Bank access channel
// One requester's path to the arbiter
////////////////////////////////////////

interface bank_if;

	// Request side, held until gnt
	logic req;
	logic we;
	axil_regs_pkg::reg_index_t index;
	axil_regs_pkg::axil_data_t wdata;
	axil_regs_pkg::axil_strb_t wstrb;

	// Arbiter side
	// gnt is combinational from req
	logic gnt;
	// Read word, valid one cycle after the granted edge
	axil_regs_pkg::axil_data_t rdata;

	modport requester (
		output req, we, index, wdata, wstrb,
		input gnt, rdata
	);

	modport arbiter (
		input req, we, index, wdata, wstrb,
		output gnt, rdata
	);

endinterface

// File: axil_regs_pkg.sv
////////////////////////////////////////
// AXI-lite register slave types
// Widths, response codes, port FSM states
////////////////////////////////////////

`include "axil_regs_config.svh"

package axil_regs_pkg;

	// Bus widths
	typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
	typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
	typedef logic [`AXIL_DATA_W/8-1:0] axil_strb_t;

	// Word index into the bank
	typedef logic [$clog2(`AXIL_REG_COUNT)-1:0] reg_index_t;

	// Response codes, EXOKAY and DECERR never produced
	typedef logic [1:0] axil_resp_t;
	localparam axil_resp_t RESP_OKAY = 2'b00;
	localparam axil_resp_t RESP_SLVERR = 2'b10;

	// Port FSMs
	typedef enum logic [1:0] {WR_COLLECT, WR_BANK, WR_RESP} wr_state_t;
	typedef enum logic [1:0] {RD_IDLE, RD_BANK, RD_WAIT, RD_RESP} rd_state_t;

endpackage

// File: axil_regs_config.svh
////////////////////////////////////////
// AXI-lite register slave sizes
// Bus widths and bank depth
////////////////////////////////////////

`ifndef AXIL_REGS_CONFIG_SVH
`define AXIL_REGS_CONFIG_SVH

// Byte address width of the slave
`define AXIL_ADDR_W 12

// Data width, fixed for AXI-lite here
`define AXIL_DATA_W 32

// Words in the register bank
`define AXIL_REG_COUNT 16

`endif
